//--- design/malloc_pkg.sv
package malloc_pkg;

  // data word
  localparam int DATA_W = 16;

  // bank geometry, 4 banks of 16 rows
  localparam int NUM_BANKS = 4;
  localparam int BANK_W = 2;
  localparam int NUM_ROWS = 16;
  localparam int ROW_W = 4;

  // free count must reach NUM_ROWS, so one bit wider than a row index
  localparam int CNT_W = 5;

  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [DATA_W-1:0] data_t;

  // external address, bank in the upper bits
  typedef struct packed {
    bank_t bank;
    row_t  row;
  } addr_t;

  // tag carried by each read pipeline stage
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    RETURN
  } rd_stage_e;

endpackage

//--- design/alloc_if.sv
// allocation path from the write side into the bank store
interface alloc_if;

  // remove the head row of pop_bank and write wdata into it
  logic              pop;
  malloc_pkg::bank_t pop_bank;
  malloc_pkg::data_t wdata;

  // current head row of every bank, only valid while its empty bit is low
  malloc_pkg::row_t [malloc_pkg::NUM_BANKS-1:0] head_row;
  logic [malloc_pkg::NUM_BANKS-1:0] empty;

  modport producer (
    output pop,
    output pop_bank,
    output wdata,
    input  head_row,
    input  empty
  );

  modport store (
    input  pop,
    input  pop_bank,
    input  wdata,
    output head_row,
    output empty
  );

endinterface

//--- design/read_if.sv
// read and release path from the read pipeline into the bank store
interface read_if;

  // rd issues a registered read of rd_addr
  logic              rd;
  malloc_pkg::addr_t rd_addr;

  // with rd, push the row of rd_addr back onto its free list
  logic              rel;

  // word of the last issued read, valid from the cycle after rd
  malloc_pkg::data_t rd_data;

  modport reader (
    output rd,
    output rd_addr,
    output rel,
    input  rd_data
  );

  modport store (
    input  rd,
    input  rd_addr,
    input  rel,
    output rd_data
  );

endinterface

//--- design/write_alloc.sv
module write_alloc (
  input  logic              clk,
  input  logic              rst,
  input  logic              write,
  input  malloc_pkg::bank_t wr_bank,
  input  malloc_pkg::data_t din,
  output logic              alloc_vld,
  output malloc_pkg::addr_t alloc_adr,
  alloc_if.producer         af
);

  logic accept;

  // the empty flag of a bank is its back-pressure bit
  assign accept = write && !af.empty[wr_bank];

  assign af.pop      = accept;
  assign af.pop_bank = wr_bank;
  assign af.wdata    = din;

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_vld <= 1'b0;
    end else begin
      alloc_vld <= accept;
    end
  end

  // the head row leaves the free list at this edge, so capture it now
  always_ff @(posedge clk) begin
    if (accept) begin
      alloc_adr.bank <= wr_bank;
      alloc_adr.row  <= af.head_row[wr_bank];
    end
  end

  // client honours wr_bp, so a pop never hits an empty bank
  a_no_write_on_bp: assert property (
    @(posedge clk) disable iff (rst)
    write |-> !af.empty[wr_bank]
  );

  // the row handed out is gone from the head of its bank one cycle later
  a_head_moved: assert property (
    @(posedge clk) disable iff (rst)
    accept |=> (af.empty[$past(wr_bank)] ||
                (af.head_row[$past(wr_bank)] != alloc_adr.row))
  );

endmodule

//--- design/free_list.sv
module free_list (
  input  logic             clk,
  input  logic             rst,
  input  logic             pop,
  input  logic             push,
  input  malloc_pkg::row_t push_row,
  output malloc_pkg::row_t head,
  output logic             empty
);

  // next-row link of every row that is on the list
  malloc_pkg::row_t next_row [malloc_pkg::NUM_ROWS];
  malloc_pkg::row_t tail;
  malloc_pkg::cnt_t count;
  logic             last;

  assign empty = (count == '0);

  // only one row left, a pop takes the whole list
  assign last = (count == malloc_pkg::cnt_t'(1));

  // link table, reset chains row i to row i+1
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < malloc_pkg::NUM_ROWS; i++) begin
        next_row[i] <= malloc_pkg::row_t'(i + 1);
      end
    end else if (push && !empty) begin
      next_row[tail] <= push_row;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= malloc_pkg::row_t'(malloc_pkg::NUM_ROWS - 1);
      count <= malloc_pkg::cnt_t'(malloc_pkg::NUM_ROWS);
    end else begin
      case ({pop, push})
        2'b10: begin
          head  <= next_row[head];
          count <= count - malloc_pkg::cnt_t'(1);
        end
        2'b01: begin
          // pushed row becomes the head of an empty list
          if (empty) begin
            head <= push_row;
          end
          tail  <= push_row;
          count <= count + malloc_pkg::cnt_t'(1);
        end
        2'b11: begin
          // count stays, the head walks on unless the popped row was the last one
          if (last) begin
            head <= push_row;
          end else begin
            head <= next_row[head];
          end
          tail <= push_row;
        end
        default: begin
        end
      endcase
    end
  end

  // a double release would push the count past the bank size
  a_count_range: assert property (
    @(posedge clk) disable iff (rst)
    count <= malloc_pkg::cnt_t'(malloc_pkg::NUM_ROWS)
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> !empty
  );

endmodule

//--- design/bank_store.sv
module bank_store (
  input  logic                              clk,
  input  logic                              rst,
  alloc_if.store                            af,
  read_if.store                             rf,
  output logic [malloc_pkg::NUM_BANKS-1:0]  wr_bp
);

  malloc_pkg::data_t mem [malloc_pkg::NUM_BANKS][malloc_pkg::NUM_ROWS];

  // write lands in the row popped at the same edge
  always_ff @(posedge clk) begin
    if (af.pop) begin
      mem[af.pop_bank][af.head_row[af.pop_bank]] <= af.wdata;
    end
  end

  // registered read port, this flop is the data stage of the read pipeline
  always_ff @(posedge clk) begin
    if (rf.rd) begin
      rf.rd_data <= mem[rf.rd_addr.bank][rf.rd_addr.row];
    end
  end

  for (genvar b = 0; b < malloc_pkg::NUM_BANKS; b++) begin : g_bank
    logic pop_b;
    logic push_b;

    assign pop_b  = af.pop && (af.pop_bank == malloc_pkg::bank_t'(b));
    assign push_b = rf.rd && rf.rel && (rf.rd_addr.bank == malloc_pkg::bank_t'(b));

    free_list u_free_list (
      .clk      (clk),
      .rst      (rst),
      .pop      (pop_b),
      .push     (push_b),
      .push_row (rf.rd_addr.row),
      .head     (af.head_row[b]),
      .empty    (af.empty[b])
    );
  end

  assign wr_bp = af.empty;

  // a read of the row being allocated means the client read a free row
  a_read_not_free: assert property (
    @(posedge clk) disable iff (rst)
    (af.pop && rf.rd && (af.pop_bank == rf.rd_addr.bank)) |->
      (af.head_row[af.pop_bank] != rf.rd_addr.row)
  );

endmodule

//--- design/read_pipe.sv
module read_pipe (
  input  logic              clk,
  input  logic              rst,
  input  logic              read,
  input  malloc_pkg::addr_t rd_adr,
  input  logic              rd_deq,
  output logic              rd_vld,
  output malloc_pkg::data_t dout,
  read_if.reader            rf
);

  malloc_pkg::rd_stage_e s1_stage;
  malloc_pkg::rd_stage_e s2_stage;
  malloc_pkg::addr_t     s1_adr;
  logic                  s1_deq;

  // each stage keeps its own tag so one read can sit in each stage
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_stage <= malloc_pkg::IDLE;
      s2_stage <= malloc_pkg::IDLE;
    end else begin
      s1_stage <= read ? malloc_pkg::FETCH : malloc_pkg::IDLE;
      s2_stage <= (s1_stage == malloc_pkg::FETCH) ? malloc_pkg::RETURN : malloc_pkg::IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      s1_adr <= rd_adr;
      s1_deq <= rd_deq;
    end
  end

  // release goes out with the read since the row is free once its word is captured
  assign rf.rd      = (s1_stage == malloc_pkg::FETCH);
  assign rf.rd_addr = s1_adr;
  assign rf.rel     = (s1_stage == malloc_pkg::FETCH) && s1_deq;

  // the word sits in the store's read register during stage two
  assign rd_vld = (s2_stage == malloc_pkg::RETURN);
  assign dout   = rf.rd_data;

  // a second dequeue of the row already being released would link it twice
  a_no_double_release: assert property (
    @(posedge clk) disable iff (rst)
    (read && rd_deq && rf.rel) |-> (rd_adr != s1_adr)
  );

endmodule

//--- design/malloc_mem_top.sv
module malloc_mem_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             write,
  input  malloc_pkg::bank_t                wr_bank,
  input  malloc_pkg::data_t                din,
  input  logic                             read,
  input  malloc_pkg::addr_t                rd_adr,
  input  logic                             rd_deq,
  output logic [malloc_pkg::NUM_BANKS-1:0] wr_bp,
  output logic                             alloc_vld,
  output malloc_pkg::addr_t                alloc_adr,
  output logic                             rd_vld,
  output malloc_pkg::data_t                dout
);

  alloc_if u_alloc_if ();
  read_if  u_read_if ();

  write_alloc u_write_alloc (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_bank   (wr_bank),
    .din       (din),
    .alloc_vld (alloc_vld),
    .alloc_adr (alloc_adr),
    .af        (u_alloc_if.producer)
  );

  bank_store u_bank_store (
    .clk   (clk),
    .rst   (rst),
    .af    (u_alloc_if.store),
    .rf    (u_read_if.store),
    .wr_bp (wr_bp)
  );

  read_pipe u_read_pipe (
    .clk    (clk),
    .rst    (rst),
    .read   (read),
    .rd_adr (rd_adr),
    .rd_deq (rd_deq),
    .rd_vld (rd_vld),
    .dout   (dout),
    .rf     (u_read_if.reader)
  );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst
);

  // 8-unit period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held high over the first 5 rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- verif/tb_checker.sv
module tb_checker (
  input  logic                             clk,
  input  logic                             rst,
  input  int                               cyc,
  input  logic [malloc_pkg::NUM_BANKS-1:0] wr_bp,
  input  logic                             alloc_vld,
  input  malloc_pkg::addr_t                alloc_adr,
  input  logic                             rd_vld,
  input  malloc_pkg::data_t                dout,
  input  logic [malloc_pkg::NUM_BANKS-1:0] exp_bp
);

  int    alloc_errs = 0;
  int    read_errs = 0;
  int    bp_errs = 0;
  string test_name = "none";

  // expected responses, each stamped with the cycle it must show up in
  int                alloc_at [$];
  malloc_pkg::addr_t alloc_exp [$];
  string             alloc_test [$];
  int                read_at [$];
  malloc_pkg::data_t read_exp [$];
  string             read_test [$];

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic expect_alloc(input int at, input malloc_pkg::addr_t adr);
    alloc_at.push_back(at);
    alloc_exp.push_back(adr);
    alloc_test.push_back(test_name);
  endtask

  task automatic expect_read(input int at, input malloc_pkg::data_t data);
    read_at.push_back(at);
    read_exp.push_back(data);
    read_test.push_back(test_name);
  endtask

  function automatic int pending();
    return alloc_at.size() + read_at.size();
  endfunction

  task automatic check_alloc();
    logic due;
    due = (alloc_at.size() > 0) && (alloc_at[0] == cyc);
    if (alloc_vld && !due) begin
      $display("%s: alloc_vld high at cycle %0d with no write outstanding", test_name, cyc);
      alloc_errs++;
    end else if (due) begin
      if (!alloc_vld) begin
        $display("%s: alloc_vld stayed low at cycle %0d after an accepted write",
                 alloc_test[0], cyc);
        alloc_errs++;
      end else if (alloc_adr !== alloc_exp[0]) begin
        $display("FAIL %s: alloc_adr expected %h actual %h",
                 alloc_test[0], alloc_exp[0], alloc_adr);
        alloc_errs++;
      end
      alloc_at.delete(0);
      alloc_exp.delete(0);
      alloc_test.delete(0);
    end
  endtask

  task automatic check_read();
    logic due;
    due = (read_at.size() > 0) && (read_at[0] == cyc);
    if (rd_vld && !due) begin
      $display("%s: rd_vld high at cycle %0d with no read outstanding", test_name, cyc);
      read_errs++;
    end else if (due) begin
      if (!rd_vld) begin
        $display("%s: rd_vld stayed low at cycle %0d after an accepted read",
                 read_test[0], cyc);
        read_errs++;
      end else if (dout !== read_exp[0]) begin
        $display("FAIL %s: dout expected %h actual %h", read_test[0], read_exp[0], dout);
        read_errs++;
      end
      read_at.delete(0);
      read_exp.delete(0);
      read_test.delete(0);
    end
  endtask

  // outputs settle after the rising edge, so compare mid cycle
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      check_alloc();
      check_read();
      if (wr_bp !== exp_bp) begin
        $display("FAIL %s: wr_bp expected %b actual %b", test_name, exp_bp, wr_bp);
        bp_errs++;
      end
    end
  end

endmodule

//--- verif/tb_top.sv
module tb_top;

  logic                             clk;
  logic                             rst;
  logic                             write;
  malloc_pkg::bank_t                wr_bank;
  malloc_pkg::data_t                din;
  logic                             read;
  malloc_pkg::addr_t                rd_adr;
  logic                             rd_deq;
  logic [malloc_pkg::NUM_BANKS-1:0] wr_bp;
  logic                             alloc_vld;
  malloc_pkg::addr_t                alloc_adr;
  logic                             rd_vld;
  malloc_pkg::data_t                dout;

  // model keeps a ring of free rows per bank and the words held by allocated addresses
  malloc_pkg::row_t  free_rows [malloc_pkg::NUM_BANKS][malloc_pkg::NUM_ROWS];
  int                free_head [malloc_pkg::NUM_BANKS];
  int                free_cnt [malloc_pkg::NUM_BANKS];
  logic              in_use [malloc_pkg::NUM_BANKS*malloc_pkg::NUM_ROWS];
  malloc_pkg::data_t stored [malloc_pkg::NUM_BANKS*malloc_pkg::NUM_ROWS];
  // a dequeued row is usable by writes two stimulus cycles after its read
  logic              rel_v [2];
  malloc_pkg::addr_t rel_a [2];
  logic [malloc_pkg::NUM_BANKS-1:0] exp_bp;
  logic [15:0]       lfsr;
  int                cyc = 0;
  int                timeout_errs;
  int                total_errs;

  tb_clock u_clock (.clk (clk), .rst (rst));

  malloc_mem_top UUT (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_bank   (wr_bank),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .rd_deq    (rd_deq),
    .wr_bp     (wr_bp),
    .alloc_vld (alloc_vld),
    .alloc_adr (alloc_adr),
    .rd_vld    (rd_vld),
    .dout      (dout)
  );

  tb_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .cyc       (cyc),
    .wr_bp     (wr_bp),
    .alloc_vld (alloc_vld),
    .alloc_adr (alloc_adr),
    .rd_vld    (rd_vld),
    .dout      (dout),
    .exp_bp    (exp_bp)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic malloc_pkg::addr_t make_addr(input int bank, input int row);
    malloc_pkg::addr_t a;
    a.bank = malloc_pkg::bank_t'(bank);
    a.row  = malloc_pkg::row_t'(row);
    return a;
  endfunction

  task automatic release_row(input malloc_pkg::addr_t a);
    int slot;
    slot = (free_head[a.bank] + free_cnt[a.bank]) % malloc_pkg::NUM_ROWS;
    free_rows[a.bank][slot] = a.row;
    free_cnt[a.bank]++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    write  = 1'b0;
    read   = 1'b0;
    rd_deq = 1'b0;
    if (rel_v[1]) begin
      release_row(rel_a[1]);
    end
    rel_v[1] = rel_v[0];
    rel_a[1] = rel_a[0];
    rel_v[0] = 1'b0;
    // model lists now match the DUT lists after this edge
    for (int b = 0; b < malloc_pkg::NUM_BANKS; b++) begin
      exp_bp[b] = (free_cnt[b] == 0);
    end
  endtask

  task automatic issue_write(input malloc_pkg::bank_t bank, input malloc_pkg::data_t data);
    malloc_pkg::addr_t a;
    a.bank = bank;
    a.row  = free_rows[bank][free_head[bank]];
    free_head[bank] = (free_head[bank] + 1) % malloc_pkg::NUM_ROWS;
    free_cnt[bank]--;
    in_use[a] = 1'b1;
    stored[a] = data;
    write   = 1'b1;
    wr_bank = bank;
    din     = data;
    u_checker.expect_alloc(cyc + 1, a);
  endtask

  task automatic issue_read(input malloc_pkg::addr_t a, input logic deq);
    read   = 1'b1;
    rd_adr = a;
    rd_deq = deq;
    u_checker.expect_read(cyc + 2, stored[a]);
    if (deq) begin
      in_use[a] = 1'b0;
      rel_v[0]  = 1'b1;
      rel_a[0]  = a;
    end
  endtask

  task automatic random_cycle();
    int   start;
    int   idx;
    logic done;
    next_cycle();
    done = 1'b0;
    if (rand_bits(2) != 16'd0) begin
      start = int'(rand_bits(6));
      for (int k = 0; k < malloc_pkg::NUM_BANKS*malloc_pkg::NUM_ROWS; k++) begin
        idx = (start + k) % (malloc_pkg::NUM_BANKS*malloc_pkg::NUM_ROWS);
        if (!done && in_use[idx]) begin
          issue_read(malloc_pkg::addr_t'(idx), rand_bits(1) != 16'd0);
          done = 1'b1;
        end
      end
    end
    done = 1'b0;
    if (rand_bits(1) != 16'd0) begin
      start = int'(rand_bits(2));
      for (int k = 0; k < malloc_pkg::NUM_BANKS; k++) begin
        idx = (start + k) % malloc_pkg::NUM_BANKS;
        if (!done && free_cnt[idx] > 0) begin
          issue_write(malloc_pkg::bank_t'(idx), rand_bits(16));
          done = 1'b1;
        end
      end
    end
  endtask

  initial begin
    int n;
    int rel_rows [4];
    rel_rows = '{7, 2, 9, 12};
    write   = 1'b0;
    wr_bank = '0;
    din     = '0;
    read    = 1'b0;
    rd_adr  = '0;
    rd_deq  = 1'b0;
    lfsr    = 16'd64327;
    for (int b = 0; b < malloc_pkg::NUM_BANKS; b++) begin
      free_head[b] = 0;
      free_cnt[b]  = malloc_pkg::NUM_ROWS;
      for (int r = 0; r < malloc_pkg::NUM_ROWS; r++) begin
        free_rows[b][r] = malloc_pkg::row_t'(r);
      end
    end
    for (int i = 0; i < malloc_pkg::NUM_BANKS*malloc_pkg::NUM_ROWS; i++) begin
      in_use[i] = 1'b0;
    end
    rel_v[0]     = 1'b0;
    rel_v[1]     = 1'b0;
    exp_bp       = '0;
    timeout_errs = 0;

    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      next_cycle();
      n++;
    end
    if (rst !== 1'b0) begin
      $display("timeout: reset was never released");
      timeout_errs++;
    end

    u_checker.set_test("reset_idle");
    repeat (4) next_cycle();

    // rows 0 to 15 come out in order and then the bank is full
    u_checker.set_test("fill_bank");
    for (int i = 0; i < malloc_pkg::NUM_ROWS; i++) begin
      next_cycle();
      issue_write('0, rand_bits(16));
    end
    repeat (3) next_cycle();

    u_checker.set_test("back_to_back_reads");
    for (int r = 3; r < 7; r++) begin
      next_cycle();
      issue_read(make_addr(0, r), 1'b0);
    end

    u_checker.set_test("release_order");
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      issue_read(make_addr(0, rel_rows[i]), 1'b1);
    end
    repeat (2) next_cycle();
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      issue_write('0, rand_bits(16));
    end

    u_checker.set_test("random_mix");
    repeat (800) random_cycle();

    u_checker.set_test("drain");
    n = 0;
    while (u_checker.pending() != 0 && n < 10) begin
      next_cycle();
      n++;
    end
    if (u_checker.pending() != 0) begin
      $display("timeout: %0d responses never arrived", u_checker.pending());
      timeout_errs++;
    end

    total_errs = u_checker.alloc_errs + u_checker.read_errs + u_checker.bp_errs + timeout_errs;
    $display("errors: alloc_adr %0d, dout %0d, wr_bp %0d, timeout %0d",
             u_checker.alloc_errs, u_checker.read_errs, u_checker.bp_errs, timeout_errs);
    if (total_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/malloc_pkg.sv
design/alloc_if.sv
design/read_if.sv
design/write_alloc.sv
design/free_list.sv
design/bank_store.sv
design/read_pipe.sv
design/malloc_mem_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f filelist.f \
  --Mdir obj_dir -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
